/* Bender.yml */
package:
  name: issue_top

sources:
  - files:
      - source/issue_pkg.sv
      - source/pair_decoder.sv
      - source/issue_split.sv
      - source/alu_lane.sv
      - source/regfile.sv
      - source/wb_arbiter.sv
      - source/issue_top.sv
  - target: simulation
    files:
      - sim/tb_issue_top.sv

/* sim/tb_issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_issue_top import issue_pkg::*; ();

    localparam int num_pairs = 400;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  flush;
    logic                  in_valid;
    logic [xlen-1:0]       inst0;
    logic [xlen-1:0]       inst1;
    logic                  in_ready;
    logic                  dual_issue;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_addr;
    logic [xlen-1:0]       wb_data;

    // program-order model and the expected write stream
    logic [xlen-1:0]       model_regs [0:31];
    logic [reg_addr_w-1:0] exp_addr [0:2*num_pairs-1];
    logic [xlen-1:0]       exp_data [0:2*num_pairs-1];
    int                    head;
    int                    tail;
    logic [reg_addr_w-1:0] cur_addr;
    logic [xlen-1:0]       cur_data;
    logic                  exp_dual;
    logic                  exp_coll;
    logic                  coll_q;
    logic                  half_q;
    logic                  started;
    bit                    coll_next;
    bit                    flush_coll_pending;
    int                    err_wb;
    int                    err_issue;
    int                    err_misc;

    issue_top i_dut (
        .clk, .rst, .flush, .in_valid, .inst0, .inst1,
        .in_ready, .dual_issue, .wb_en, .wb_addr, .wb_data
    );

    always #4 clk = ~clk;

    function automatic logic alu_word(input instr_word_u w);
        return w.r3.opcode inside {op_add_w, op_sub_w, op_and, op_or, op_xor} ||
               w.ri12.opcode == op_addi_w;
    endfunction

    // addi.w has no rk source
    function automatic logic [reg_addr_w-1:0] rk_src(input instr_word_u w);
        return (w.ri12.opcode == op_addi_w) ? '0 : w.r3.rk;
    endfunction

    function automatic logic dual_rule(input instr_word_u a, input instr_word_u b);
        if (!alu_word(a) || !alu_word(b)) begin
            return 1'b0;
        end
        if (a.r3.rd == '0 || b.r3.rd == '0) begin
            return 1'b1;
        end
        return a.r3.rd != b.r3.rj && a.r3.rd != rk_src(b) &&
               b.r3.rd != a.r3.rj && b.r3.rd != rk_src(a);
    endfunction

    function automatic logic [xlen-1:0] alu_result(input instr_word_u w);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a = model_regs[w.r3.rj];
        b = model_regs[w.r3.rk];
        if (w.ri12.opcode == op_addi_w) begin
            return a + {{(xlen-12){w.ri12.imm12[11]}}, w.ri12.imm12};
        end
        case (w.r3.opcode)
            op_add_w: return a + b;
            op_sub_w: return a - b;
            op_and:   return a & b;
            op_or:    return a | b;
            op_xor:   return a ^ b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] rand_inst();
        instr_word_u w;
        int unsigned sel;
        sel = $urandom_range(0, 15);
        w = '0;
        if (sel < 6) begin
            w.ri12.opcode = op_addi_w;
            w.ri12.imm12  = 12'($urandom);
        end else if (sel < 15) begin
            case (sel % 5)
                0: w.r3.opcode = op_add_w;
                1: w.r3.opcode = op_sub_w;
                2: w.r3.opcode = op_and;
                3: w.r3.opcode = op_or;
                default: w.r3.opcode = op_xor;
            endcase
            w.r3.rk = 5'($urandom_range(0, 7));
        end else begin
            // top bits outside both opcode maps
            w = $urandom;
            w.ri12.opcode = 10'h3ff;
        end
        w.r3.rj = 5'($urandom_range(0, 7));
        w.r3.rd = 5'($urandom_range(0, 7));
        return w;
    endfunction

    task automatic retire(input instr_word_u w);
        logic [xlen-1:0] res;
        res = alu_result(w);
        if (alu_word(w) && w.r3.rd != '0) begin
            model_regs[w.r3.rd] = res;
            exp_addr[tail] = w.r3.rd;
            exp_data[tail] = res;
            tail++;
        end
    endtask

    // one cycle with nothing offered, consumes a pending collision flush
    task automatic idle_cycle();
        in_valid = 1'b0;
        flush = flush_coll_pending;
        flush_coll_pending = 1'b0;
        coll_next = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic send_pair(input logic [xlen-1:0] i0, input logic [xlen-1:0] i1,
                             input bit want_flush);
        bit split;
        bit coll_pair;
        bit drop1;
        bit accepted;
        int sh_cyc;
        int cyc;
        split = !dual_rule(i0, i1);
        coll_pair = !split && i0[4:0] != '0 && i1[4:0] != '0;
        drop1 = want_flush && (split || coll_pair);
        // busy cycle first when the last pair collided
        sh_cyc = coll_next ? 2 : 1;
        retire(i0);
        if (!drop1) begin
            retire(i1);
        end
        in_valid = 1'b1;
        inst0 = i0;
        inst1 = i1;
        accepted = 1'b0;
        cyc = 0;
        while (!accepted) begin
            flush = (cyc == 0 && flush_coll_pending) || (drop1 && split && cyc == sh_cyc);
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            #1;
            cyc++;
        end
        flush_coll_pending = drop1 && coll_pair;
        coll_next = coll_pair;
    endtask

    assign cur_addr = exp_addr[head];
    assign cur_data = exp_data[head];
    assign exp_coll = exp_dual && inst0[4:0] != '0 && inst1[4:0] != '0;

    always_comb begin
        exp_dual = dual_rule(inst0, inst1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= 0;
            coll_q  <= 1'b0;
            half_q  <= 1'b0;
            started <= 1'b0;
        end else begin
            if (wb_en) begin
                head <= head + 1;
            end
            coll_q  <= in_valid && in_ready && exp_coll;
            half_q  <= in_valid && !exp_dual && !coll_q && !half_q;
            started <= started || in_valid;
        end
    end

    a_wb_pending: assert property (@(posedge clk) disable iff (rst) wb_en |-> head != tail)
        else begin
            err_wb++;
            $display("unexpected write to r%0d, no write was pending", $sampled(wb_addr));
        end

    a_wb_addr: assert property (@(posedge clk) disable iff (rst)
        wb_en && head != tail |-> wb_addr == cur_addr)
        else begin
            err_wb++;
            $display("ERR wb_addr exp %h got %h", $sampled(cur_addr), $sampled(wb_addr));
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        wb_en && head != tail |-> wb_data == cur_data)
        else begin
            err_wb++;
            $display("ERR wb_data exp %h got %h", $sampled(cur_data), $sampled(wb_data));
        end

    a_wb_not_r0: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_addr != '0)
        else begin
            err_wb++;
            $display("ERR wb_addr exp nonzero got %h", $sampled(wb_addr));
        end

    a_dual_match: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |-> dual_issue == exp_dual)
        else begin
            err_issue++;
            $display("ERR dual_issue exp %h got %h", $sampled(exp_dual), $sampled(dual_issue));
        end

    a_dual_on_accept: assert property (@(posedge clk) disable iff (rst)
        dual_issue |-> in_valid && in_ready)
        else begin
            err_issue++;
            $display("dual_issue raised in a cycle that accepted no pair");
        end

    a_split_one_stall: assert property (@(posedge clk) disable iff (rst)
        in_valid && !exp_dual && !coll_q && !half_q |-> !in_ready ##1 in_ready)
        else begin
            err_issue++;
            $display("split pair did not hold in_ready low for exactly one cycle");
        end

    a_coll_stall: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready && exp_coll |=> !in_ready && wb_en)
        else begin
            err_issue++;
            $display("colliding dual pair did not stall with the lane 0 write");
        end

    a_coll_drain: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready && exp_coll ##1 !flush |=> wb_en)
        else begin
            err_issue++;
            $display("held lane 1 write did not follow the lane 0 write");
        end

    a_reset_state: assert property (@(posedge clk) disable iff (rst)
        !started && !in_valid |-> in_ready && !wb_en && !dual_issue)
        else begin
            err_misc++;
            $display("outputs after reset are not idle with in_ready high");
        end

    initial begin
        #(20 * num_pairs * 8);
        $display("watchdog expired with %0d writes still outstanding", tail - head);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h5f3ab462));
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        inst0 = inst_nop;
        inst1 = inst_nop;
        tail = 0;
        err_wb = 0;
        err_issue = 0;
        err_misc = 0;
        coll_next = 1'b0;
        flush_coll_pending = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) idle_cycle();
        for (int n = 0; n < num_pairs; n++) begin
            if ($urandom_range(0, 7) == 0) begin
                idle_cycle();
            end
            send_pair(rand_inst(), rand_inst(), $urandom_range(0, 11) == 0);
        end
        idle_cycle();
        flush = 1'b0;
        while (head != tail) begin
            @(posedge clk);
        end
        // a stray write would show up here
        repeat (5) @(posedge clk);
        $display("errors: writeback %0d, issue %0d, other %0d", err_wb, err_issue, err_misc);
        if (err_wb + err_issue + err_misc == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/alu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_lane import issue_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic                  issue,
    input  wire logic [uop_w-1:0]      uop,
    input  wire logic [reg_addr_w-1:0] rd,
    input  wire logic [xlen-1:0]       opa,
    input  wire logic [xlen-1:0]       opb,
    output logic                       res_valid,
    output logic [reg_addr_w-1:0]      res_rd,
    output logic [xlen-1:0]            res_data
);

    logic [xlen-1:0] alu_out;
    logic            writes_rd;

    always_comb begin
        case (uop)
            uop_add: alu_out = opa + opb;
            uop_sub: alu_out = opa - opb;
            uop_and: alu_out = opa & opb;
            uop_or:  alu_out = opa | opb;
            uop_xor: alu_out = opa ^ opb;
            default: alu_out = '0;
        endcase
    end

    // nops and r0 targets never reach the write port
    assign writes_rd = issue && uop != uop_nop && rd != '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= writes_rd;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (writes_rd) begin
            res_rd   <= rd;
            res_data <= alu_out;
        end
    end

endmodule

`default_nettype wire

/* source/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int uop_w      = 3;

    // micro-op codes seen by the alu lanes
    localparam logic [uop_w-1:0] uop_nop = 3'd0;
    localparam logic [uop_w-1:0] uop_add = 3'd1;
    localparam logic [uop_w-1:0] uop_sub = 3'd2;
    localparam logic [uop_w-1:0] uop_and = 3'd3;
    localparam logic [uop_w-1:0] uop_or  = 3'd4;
    localparam logic [uop_w-1:0] uop_xor = 3'd5;

    // three-register format, opcode in bits 31:15
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // register plus 12-bit immediate, opcode in bits 31:22
    localparam logic [9:0] op_addi_w = 10'h00a;

    // addi.w r0, r0, 0
    localparam logic [xlen-1:0] inst_nop = 32'h0280_0000;

    // one instruction word, two decode views
    typedef union packed {
        struct packed {
            logic [16:0]           opcode;
            logic [reg_addr_w-1:0] rk;
            logic [reg_addr_w-1:0] rj;
            logic [reg_addr_w-1:0] rd;
        } r3;
        struct packed {
            logic [9:0]            opcode;
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rj;
            logic [reg_addr_w-1:0] rd;
        } ri12;
    } instr_word_u;

endpackage

`default_nettype wire

/* source/issue_split.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_split import issue_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic                  in_valid,
    input  wire logic                  busy,
    input  wire logic                  is_alu0,
    input  wire logic                  is_alu1,
    input  wire logic [uop_w-1:0]      uop0,
    input  wire logic [uop_w-1:0]      uop1,
    input  wire logic [reg_addr_w-1:0] rd0,
    input  wire logic [reg_addr_w-1:0] rd1,
    input  wire logic [reg_addr_w-1:0] rj0,
    input  wire logic [reg_addr_w-1:0] rj1,
    input  wire logic [reg_addr_w-1:0] rk0,
    input  wire logic [reg_addr_w-1:0] rk1,
    input  wire logic [xlen-1:0]       imm0,
    input  wire logic [xlen-1:0]       imm1,
    input  wire logic                  use_imm0,
    input  wire logic                  use_imm1,
    input  wire logic [xlen-1:0]       rdata0,
    input  wire logic [xlen-1:0]       rdata1,
    input  wire logic [xlen-1:0]       rdata2,
    input  wire logic [xlen-1:0]       rdata3,
    output logic                       in_ready,
    output logic                       dual_issue,
    output logic [reg_addr_w-1:0]      ra0,
    output logic [reg_addr_w-1:0]      ra1,
    output logic [reg_addr_w-1:0]      ra2,
    output logic [reg_addr_w-1:0]      ra3,
    output logic                       issue0,
    output logic                       issue1,
    output logic [uop_w-1:0]           uop_l0,
    output logic [uop_w-1:0]           uop_l1,
    output logic [reg_addr_w-1:0]      rd_l0,
    output logic [reg_addr_w-1:0]      rd_l1,
    output logic [xlen-1:0]            opa_l0,
    output logic [xlen-1:0]            opb_l0,
    output logic [xlen-1:0]            opa_l1,
    output logic [xlen-1:0]            opb_l1
);

    instr_word_u     nop_w;
    logic            pair_dual;
    logic            second_half;
    logic            sel_imm_l0;
    logic            sel_imm_l1;
    logic [xlen-1:0] imm_l0;
    logic [xlen-1:0] imm_l1;

    assign nop_w = inst_nop;

    // both alu and no cross dependency, or a zero destination
    assign pair_dual = is_alu0 && is_alu1 &&
                       ((rd0 != rj1 && rd0 != rk1 && rd1 != rj0 && rd1 != rk0) ||
                        rd0 == '0 || rd1 == '0);

    assign issue0     = in_valid && !busy;
    assign dual_issue = in_valid && !busy && !second_half && pair_dual;
    assign issue1     = dual_issue;
    // idle input counts as ready
    assign in_ready   = !busy && (!in_valid || second_half || pair_dual);

    // set while inst1 still waits for its own cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            second_half <= 1'b0;
        end else if (in_valid && !busy) begin
            second_half <= !second_half && !pair_dual;
        end
    end

    always_comb begin
        ra0        = rj0;
        ra1        = rk0;
        uop_l0     = uop0;
        rd_l0      = rd0;
        sel_imm_l0 = use_imm0;
        imm_l0     = imm0;
        ra2        = rj1;
        ra3        = rk1;
        uop_l1     = uop1;
        rd_l1      = rd1;
        sel_imm_l1 = use_imm1;
        imm_l1     = imm1;
        // second cycle of a split pair, inst1 moves to lane 0
        if (second_half) begin
            ra0        = rj1;
            ra1        = rk1;
            uop_l0     = uop1;
            rd_l0      = rd1;
            sel_imm_l0 = use_imm1;
            imm_l0     = imm1;
        end
        // lane 1 idle, fill with the nop word
        if (second_half || !pair_dual) begin
            ra2        = nop_w.ri12.rj;
            ra3        = nop_w.ri12.rj;
            uop_l1     = uop_nop;
            rd_l1      = nop_w.ri12.rd;
            sel_imm_l1 = 1'b1;
            imm_l1     = {{(xlen-12){nop_w.ri12.imm12[11]}}, nop_w.ri12.imm12};
        end
    end

    assign opa_l0 = rdata0;
    assign opb_l0 = sel_imm_l0 ? imm_l0 : rdata1;
    assign opa_l1 = rdata2;
    assign opb_l1 = sel_imm_l1 ? imm_l1 : rdata3;

    // a held pair must stay valid until its second half issues
    a_second_half_once: assert property (@(posedge clk) disable iff (rst || flush)
        second_half && !busy |=> !second_half);

endmodule

`default_nettype wire

/* source/issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_top import issue_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic                  in_valid,
    input  wire logic [xlen-1:0]       inst0,
    input  wire logic [xlen-1:0]       inst1,
    output logic                       in_ready,
    output logic                       dual_issue,
    output logic                       wb_en,
    output logic [reg_addr_w-1:0]      wb_addr,
    output logic [xlen-1:0]            wb_data
);

    logic                  is_alu0, is_alu1;
    logic [uop_w-1:0]      uop0, uop1;
    logic [reg_addr_w-1:0] rd0, rd1, rj0, rj1, rk0, rk1;
    logic [xlen-1:0]       imm0, imm1;
    logic                  use_imm0, use_imm1;

    logic [reg_addr_w-1:0] ra0, ra1, ra2, ra3;
    logic [xlen-1:0]       rdata0, rdata1, rdata2, rdata3;

    logic                  issue0, issue1;
    logic [uop_w-1:0]      uop_l0, uop_l1;
    logic [reg_addr_w-1:0] rd_l0, rd_l1;
    logic [xlen-1:0]       opa_l0, opb_l0, opa_l1, opb_l1;

    logic                  l0_valid, l1_valid;
    logic [reg_addr_w-1:0] l0_rd, l1_rd;
    logic [xlen-1:0]       l0_data, l1_data;
    logic                  busy;

    pair_decoder u_dec (
        .inst0, .inst1,
        .is_alu0, .is_alu1, .uop0, .uop1,
        .rd0, .rd1, .rj0, .rj1, .rk0, .rk1,
        .imm0, .imm1, .use_imm0, .use_imm1
    );

    issue_split u_split (
        .clk, .rst, .flush, .in_valid, .busy,
        .is_alu0, .is_alu1, .uop0, .uop1,
        .rd0, .rd1, .rj0, .rj1, .rk0, .rk1,
        .imm0, .imm1, .use_imm0, .use_imm1,
        .rdata0, .rdata1, .rdata2, .rdata3,
        .in_ready, .dual_issue,
        .ra0, .ra1, .ra2, .ra3,
        .issue0, .issue1, .uop_l0, .uop_l1, .rd_l0, .rd_l1,
        .opa_l0, .opb_l0, .opa_l1, .opb_l1
    );

    alu_lane u_lane0 (
        .clk, .rst, .flush,
        .issue(issue0), .uop(uop_l0), .rd(rd_l0), .opa(opa_l0), .opb(opb_l0),
        .res_valid(l0_valid), .res_rd(l0_rd), .res_data(l0_data)
    );

    alu_lane u_lane1 (
        .clk, .rst, .flush,
        .issue(issue1), .uop(uop_l1), .rd(rd_l1), .opa(opa_l1), .opb(opb_l1),
        .res_valid(l1_valid), .res_rd(l1_rd), .res_data(l1_data)
    );

    // the write port is also the observable writeback
    regfile u_rf (
        .clk, .rst,
        .ra0, .ra1, .ra2, .ra3,
        .we(wb_en), .waddr(wb_addr), .wdata(wb_data),
        .rdata0, .rdata1, .rdata2, .rdata3
    );

    wb_arbiter u_arb (
        .clk, .rst, .flush,
        .l0_valid, .l0_rd, .l0_data,
        .l1_valid, .l1_rd, .l1_data,
        .we(wb_en), .waddr(wb_addr), .wdata(wb_data), .busy
    );

endmodule

`default_nettype wire

/* source/pair_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_decoder import issue_pkg::*; (
    input  wire logic [xlen-1:0]       inst0,
    input  wire logic [xlen-1:0]       inst1,
    output logic                       is_alu0,
    output logic                       is_alu1,
    output logic [uop_w-1:0]           uop0,
    output logic [uop_w-1:0]           uop1,
    output logic [reg_addr_w-1:0]      rd0,
    output logic [reg_addr_w-1:0]      rd1,
    output logic [reg_addr_w-1:0]      rj0,
    output logic [reg_addr_w-1:0]      rj1,
    output logic [reg_addr_w-1:0]      rk0,
    output logic [reg_addr_w-1:0]      rk1,
    output logic [xlen-1:0]            imm0,
    output logic [xlen-1:0]            imm1,
    output logic                       use_imm0,
    output logic                       use_imm1
);

    instr_word_u word0;
    instr_word_u word1;

    assign word0 = inst0;
    assign word1 = inst1;

    // same decode for both slots of the pair
    function automatic void decode_one(
        input  instr_word_u           w,
        output logic                  is_alu,
        output logic [uop_w-1:0]      uop,
        output logic [reg_addr_w-1:0] rd,
        output logic [reg_addr_w-1:0] rj,
        output logic [reg_addr_w-1:0] rk,
        output logic [xlen-1:0]       imm,
        output logic                  use_imm
    );
        is_alu  = 1'b1;
        use_imm = 1'b0;
        rd      = w.r3.rd;
        rj      = w.r3.rj;
        rk      = w.r3.rk;
        imm     = '0;
        case (w.r3.opcode)
            op_add_w: uop = uop_add;
            op_sub_w: uop = uop_sub;
            op_and:   uop = uop_and;
            op_or:    uop = uop_or;
            op_xor:   uop = uop_xor;
            default: begin
                if (w.ri12.opcode == op_addi_w) begin
                    uop     = uop_add;
                    use_imm = 1'b1;
                    // no rk source, keeps hazard check exact
                    rk      = '0;
                    imm     = {{(xlen-12){w.ri12.imm12[11]}}, w.ri12.imm12};
                end else begin
                    // non-alu, runs as a no-op
                    is_alu = 1'b0;
                    uop    = uop_nop;
                    rd     = '0;
                    rj     = '0;
                    rk     = '0;
                end
            end
        endcase
    endfunction

    always_comb begin
        decode_one(word0, is_alu0, uop0, rd0, rj0, rk0, imm0, use_imm0);
        decode_one(word1, is_alu1, uop1, rd1, rj1, rk1, imm1, use_imm1);
    end

endmodule

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile import issue_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [reg_addr_w-1:0] ra0,
    input  wire logic [reg_addr_w-1:0] ra1,
    input  wire logic [reg_addr_w-1:0] ra2,
    input  wire logic [reg_addr_w-1:0] ra3,
    input  wire logic                  we,
    input  wire logic [reg_addr_w-1:0] waddr,
    input  wire logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]            rdata0,
    output logic [xlen-1:0]            rdata1,
    output logic [xlen-1:0]            rdata2,
    output logic [xlen-1:0]            rdata3
);

    // r0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so a same-cycle reader sees the new value
    always_comb begin
        rdata0 = (ra0 == '0) ? '0 : (we && waddr == ra0) ? wdata : regs[ra0];
        rdata1 = (ra1 == '0) ? '0 : (we && waddr == ra1) ? wdata : regs[ra1];
        rdata2 = (ra2 == '0) ? '0 : (we && waddr == ra2) ? wdata : regs[ra2];
        rdata3 = (ra3 == '0) ? '0 : (we && waddr == ra3) ? wdata : regs[ra3];
    end

endmodule

`default_nettype wire

/* source/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import issue_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic                  l0_valid,
    input  wire logic [reg_addr_w-1:0] l0_rd,
    input  wire logic [xlen-1:0]       l0_data,
    input  wire logic                  l1_valid,
    input  wire logic [reg_addr_w-1:0] l1_rd,
    input  wire logic [xlen-1:0]       l1_data,
    output logic                       we,
    output logic [reg_addr_w-1:0]      waddr,
    output logic [xlen-1:0]            wdata,
    output logic                       busy
);

    logic                  hold_valid;
    logic [reg_addr_w-1:0] hold_rd;
    logic [xlen-1:0]       hold_data;

    // both lanes finished together, lane 1 has to wait
    assign busy = l0_valid && l1_valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= busy;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            hold_rd   <= l1_rd;
            hold_data <= l1_data;
        end
    end

    // held entry drains first, then lane 0, then lane 1
    always_comb begin
        we    = hold_valid || l0_valid || l1_valid;
        waddr = l1_rd;
        wdata = l1_data;
        if (hold_valid) begin
            waddr = hold_rd;
            wdata = hold_data;
        end else if (l0_valid) begin
            waddr = l0_rd;
            wdata = l0_data;
        end
    end

    // busy blocks issue, so nothing new lands on a draining cycle
    a_no_result_while_held: assert property (@(posedge clk) disable iff (rst)
        hold_valid |-> !l0_valid && !l1_valid);

endmodule

`default_nettype wire

/* tb.f */
source/issue_pkg.sv
source/pair_decoder.sv
source/issue_split.sv
source/alu_lane.sv
source/regfile.sv
source/wb_arbiter.sv
source/issue_top.sv
sim/tb_issue_top.sv
